/* src/zx_pkg.sv */
package zx_pkg;

	// ========================================
	// Bus and memory widths
	// ========================================

	typedef logic [15:0] cpu_addr_t;   // Z80 address bus
	typedef logic [7:0]  cpu_data_t;   // Z80 data byte
	typedef logic [20:0] ram_addr_t;   // External RAM byte address
	typedef logic [2:0]  bank_t;       // 16K RAM page
	typedef logic [3:0]  rom_page_t;   // 16K ROM page
	typedef logic [2:0]  border_t;     // Border colour
	typedef logic [4:0]  key_row_t;    // Active-low key columns

	// ========================================
	// Machine model
	// ========================================

	// Code 3 is left free
	typedef enum logic [1:0] {
		model_128   = 2'd0,
		model_48    = 2'd1,
		model_plus3 = 2'd2
	} model_t;

	// ========================================
	// Page and bus constants
	// ========================================

	// Floating data bus reads back as all ones
	localparam cpu_data_t IDLE_BUS = 8'hFF;

	// Fixed pages behind 4000 and 8000 in the normal map
	localparam bank_t SCREEN_BANK_A = 3'd5;
	localparam bank_t SCREEN_BANK_B = 3'd2;

	// 48K BASIC ROM on the 48K model
	localparam rom_page_t ROM_PAGE_48 = 4'b1111;

	// Upper ROM page bits, low bits come from the paging registers
	localparam logic [2:0] ROM_BASE_128   = 3'b011;
	localparam logic [1:0] ROM_BASE_PLUS3 = 2'b10;

endpackage

/* src/paging_regs.sv */
module paging_regs (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx_pkg::model_t     model_sel,
	input  logic               io_wr_pulse,
	input  zx_pkg::cpu_addr_t  addr,
	input  zx_pkg::cpu_data_t  cpu_dout,
	output zx_pkg::bank_t      page_ram,
	output zx_pkg::rom_page_t  page_rom,
	output logic               page_special,
	output logic [1:0]         special_cfg
);

	// ========================================
	// Register state
	// ========================================

	zx_pkg::model_t model_q;      // Sampled while reset is high

	// Port 7FFD fields
	zx_pkg::bank_t  bank_q;       // Page at C000
	logic           rom_lo_q;     // ROM select, bit 4
	logic           lock_q;       // Paging lock, bit 5

	// Port 1FFD fields
	logic           special_q;    // All-RAM mode, bit 0
	logic [1:0]     cfg_q;        // Bits 2 and 1

	logic is_plus3;
	logic is_48;
	logic page_lock;
	logic wr_7ffd;
	logic wr_1ffd;

	assign is_plus3  = (model_q == zx_pkg::model_plus3);
	assign is_48     = (model_q == zx_pkg::model_48);
	assign page_lock = is_48 | lock_q;

	// ========================================
	// Port decode
	// ========================================

	// 7FFD, the +3 also needs A14 so it does not alias 1FFD
	assign wr_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~is_plus3) & ~page_lock;

	// 1FFD exists only on the +3
	assign wr_1ffd = is_plus3 & ~addr[15] & ~addr[14] & ~addr[13] & addr[12] &
		~addr[1] & ~page_lock;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q   <= model_sel;
			bank_q    <= '0;
			rom_lo_q  <= 1'b0;
			lock_q    <= 1'b0;
			special_q <= 1'b0;
			cfg_q     <= '0;
		end else if (io_wr_pulse) begin
			if (wr_7ffd) begin
				bank_q   <= cpu_dout[2:0];
				rom_lo_q <= cpu_dout[4];
				lock_q   <= cpu_dout[5];   // Sticks until the next reset
			end else if (wr_1ffd) begin
				special_q <= cpu_dout[0];
				cfg_q     <= cpu_dout[2:1];
			end
		end
	end

	// ========================================
	// Page outputs
	// ========================================

	assign page_ram     = bank_q;
	assign page_special = special_q;
	assign special_cfg  = cfg_q;

	always_comb begin
		case (model_q)
			zx_pkg::model_plus3: begin
				// Four ROMs, picked by 1FFD bit 2 and 7FFD bit 4
				page_rom = {zx_pkg::ROM_BASE_PLUS3, cfg_q[1], rom_lo_q};
			end
			zx_pkg::model_48: begin
				page_rom = zx_pkg::ROM_PAGE_48;
			end
			default: begin
				page_rom = {zx_pkg::ROM_BASE_128, rom_lo_q};   // 128 editor or BASIC
			end
		endcase
	end

endmodule

/* src/ula_port.sv */
module ula_port (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx_pkg::cpu_addr_t  addr,
	input  zx_pkg::cpu_data_t  cpu_dout,
	input  logic               n_iorq,
	input  logic               n_wr,
	input  logic               n_m1,
	input  zx_pkg::key_row_t   key_data,
	input  logic               tape_in,
	output logic               io_wr_pulse,
	output zx_pkg::cpu_data_t  ula_rd_data,
	output zx_pkg::border_t    border_color,
	output logic               ear_out,
	output logic               mic_out
);

	logic io_wr;
	logic io_wr_q;

	// ========================================
	// I/O write edge
	// ========================================

	// Interrupt acknowledge has M1 low, so it never counts
	assign io_wr = ~n_iorq & ~n_wr & n_m1;

	// One pulse per write cycle however long the strobe is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q     <= 1'b0;
			io_wr_pulse <= 1'b0;
		end else begin
			io_wr_q     <= io_wr;
			io_wr_pulse <= io_wr & ~io_wr_q;
		end
	end

	// ========================================
	// Port FE
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= '0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (io_wr_pulse && !addr[0]) begin   // ULA decodes A0 only
			border_color <= cpu_dout[2:0];
			ear_out      <= cpu_dout[4];
			mic_out      <= cpu_dout[3];
		end
	end

	// Bits 7 and 5 float high on the real ULA
	assign ula_rd_data = {1'b1, ~tape_in, 1'b1, key_data};

endmodule

/* src/memory_bus.sv */
module memory_bus #(
	parameter logic [2:0] ROM_REGION = 3'b101
) (
	input  zx_pkg::cpu_addr_t  addr,
	input  logic               n_mreq,
	input  logic               n_iorq,
	input  logic               n_rd,
	input  logic               n_wr,
	input  logic               n_m1,
	input  zx_pkg::bank_t      page_ram,
	input  zx_pkg::rom_page_t  page_rom,
	input  logic               page_special,
	input  logic [1:0]         special_cfg,
	input  zx_pkg::cpu_data_t  ula_rd_data,
	input  zx_pkg::cpu_data_t  ram_dout,
	output zx_pkg::ram_addr_t  ram_addr,
	output logic               ram_rd,
	output logic               ram_we,
	output zx_pkg::cpu_data_t  cpu_din
);

	logic [1:0]    area;          // 16K quarter of the CPU space
	zx_pkg::bank_t spec_bank;
	logic          io_rd;
	logic          rom_area;

	assign area     = addr[15:14];
	assign rom_area = (area == 2'b00) & ~page_special;

	// ========================================
	// All-RAM page table (+3 special mode)
	// ========================================

	function automatic zx_pkg::bank_t special_bank(
		input logic [1:0] cfg,
		input logic [1:0] quarter
	);
		zx_pkg::bank_t bank;
		case (cfg)
			2'd0: bank = {1'b0, quarter};   // 0 1 2 3
			2'd1: bank = {1'b1, quarter};   // 4 5 6 7
			2'd2: begin
				// 4 5 6 3
				if (quarter == 2'd3) begin
					bank = 3'd3;
				end else begin
					bank = {1'b1, quarter};
				end
			end
			default: begin
				// 4 7 6 3
				case (quarter)
					2'd0:    bank = 3'd4;
					2'd1:    bank = 3'd7;
					2'd2:    bank = 3'd6;
					default: bank = 3'd3;
				endcase
			end
		endcase
		return bank;
	endfunction

	assign spec_bank = special_bank(special_cfg, area);

	// ========================================
	// Address map
	// ========================================

	always_comb begin
		if (page_special) begin
			ram_addr = {4'd0, spec_bank, addr[13:0]};
		end else begin
			case (area)
				2'b00:   ram_addr = {ROM_REGION, page_rom, addr[13:0]};
				2'b01:   ram_addr = {4'd0, zx_pkg::SCREEN_BANK_A, addr[13:0]};
				2'b10:   ram_addr = {4'd0, zx_pkg::SCREEN_BANK_B, addr[13:0]};
				default: ram_addr = {4'd0, page_ram, addr[13:0]};
			endcase
		end
	end

	// ========================================
	// Strobes and read data
	// ========================================

	assign ram_rd = ~n_mreq & ~n_rd;
	assign ram_we = ~n_mreq & ~n_wr & ~rom_area;   // ROM is read only

	assign io_rd = ~n_iorq & ~n_rd & n_m1;

	always_comb begin
		if (!n_mreq) begin
			cpu_din = ram_dout;
		end else if (io_rd && !addr[0]) begin
			cpu_din = ula_rd_data;   // Port FE
		end else begin
			cpu_din = zx_pkg::IDLE_BUS;
		end
	end

endmodule

/* src/zx_io_top.sv */
module zx_io_top #(
	parameter logic [2:0] ROM_REGION = 3'b101   // Top RAM bits of the ROM area
) (
	input  logic               clk_sys,
	input  logic               reset,

	// Z80 bus
	input  zx_pkg::cpu_addr_t  addr,
	input  zx_pkg::cpu_data_t  cpu_dout,
	input  logic               n_mreq,
	input  logic               n_iorq,
	input  logic               n_rd,
	input  logic               n_wr,
	input  logic               n_m1,

	input  zx_pkg::model_t     model_sel,
	input  zx_pkg::key_row_t   key_data,
	input  logic               tape_in,
	input  zx_pkg::cpu_data_t  ram_dout,

	output zx_pkg::ram_addr_t  ram_addr,
	output logic               ram_we,
	output logic               ram_rd,
	output zx_pkg::cpu_data_t  cpu_din,
	output zx_pkg::border_t    border_color,
	output logic               ear_out,
	output logic               mic_out
);

	logic               io_wr_pulse;
	zx_pkg::bank_t      page_ram;
	zx_pkg::rom_page_t  page_rom;
	logic               page_special;
	logic [1:0]         special_cfg;
	zx_pkg::cpu_data_t  ula_rd_data;

	// ========================================
	// Paging and ULA port
	// ========================================

	paging_regs u_paging (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.model_sel    (model_sel),
		.io_wr_pulse  (io_wr_pulse),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.page_ram     (page_ram),
		.page_rom     (page_rom),
		.page_special (page_special),
		.special_cfg  (special_cfg)
	);

	ula_port u_ula (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.n_iorq       (n_iorq),
		.n_wr         (n_wr),
		.n_m1         (n_m1),
		.key_data     (key_data),
		.tape_in      (tape_in),
		.io_wr_pulse  (io_wr_pulse),   // Shared with paging
		.ula_rd_data  (ula_rd_data),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	// ========================================
	// Memory side
	// ========================================

	memory_bus #(
		.ROM_REGION (ROM_REGION)
	) u_bus (
		.addr         (addr),
		.n_mreq       (n_mreq),
		.n_iorq       (n_iorq),
		.n_rd         (n_rd),
		.n_wr         (n_wr),
		.n_m1         (n_m1),
		.page_ram     (page_ram),
		.page_rom     (page_rom),
		.page_special (page_special),
		.special_cfg  (special_cfg),
		.ula_rd_data  (ula_rd_data),
		.ram_dout     (ram_dout),
		.ram_addr     (ram_addr),
		.ram_rd       (ram_rd),
		.ram_we       (ram_we),
		.cpu_din      (cpu_din)
	);

endmodule

/* dv/zx_io_asserts.sv */
module zx_io_asserts (
	input logic clk_sys,
	input logic reset,
	input logic n_mreq,
	input logic ram_we,
	input logic ram_rd,
	input logic ear_out,
	input logic mic_out
);

	// A bus cycle is either a read or a write
	we_rd_exclusive: assert property (@(posedge clk_sys) !(ram_we && ram_rd))
		else $error("ram_we and ram_rd high together");

	we_needs_mreq: assert property (@(posedge clk_sys) n_mreq |-> !ram_we)
		else $error("ram_we high without n_mreq");

	// Port FE outputs come out of reset low
	fe_reset_low: assert property (@(posedge clk_sys) reset |=> (!ear_out && !mic_out))
		else $error("ear_out or mic_out high after reset");

endmodule

bind zx_io_top zx_io_asserts u_asserts (
	.clk_sys (clk_sys),
	.reset   (reset),
	.n_mreq  (n_mreq),
	.ram_we  (ram_we),
	.ram_rd  (ram_rd),
	.ear_out (ear_out),
	.mic_out (mic_out)
);

/* dv/tb_zx_io.sv */
module tb_zx_io;

	localparam logic [2:0] ROM_AREA = 3'b101;   // Top RAM bits of the ROM area
	localparam string PATTERN_FILE = "dv/zx_io_patterns.txt";
	localparam int CYCLES_PER_LINE = 8;
	localparam int CYCLE_MARGIN = 100;

	logic               clk_sys = 1'b0;
	logic               reset;
	zx_pkg::cpu_addr_t  addr;
	zx_pkg::cpu_data_t  cpu_dout;
	logic               n_mreq, n_iorq, n_rd, n_wr, n_m1;
	zx_pkg::model_t     model_sel;
	zx_pkg::key_row_t   key_data;
	logic               tape_in;
	zx_pkg::cpu_data_t  ram_dout;
	zx_pkg::ram_addr_t  ram_addr;
	logic               ram_we, ram_rd;
	zx_pkg::cpu_data_t  cpu_din;
	zx_pkg::border_t    border_color;
	logic               ear_out, mic_out;

	int          fd, n, lines, checks, cycle_count, cycle_limit;
	string       line, cmd;
	logic [31:0] model_v, addr_v, data_v, exp_v, key_v, tape_v;

	zx_io_top #(.ROM_REGION(ROM_AREA)) u_dut (
		.clk_sys (clk_sys), .reset (reset), .addr (addr), .cpu_dout (cpu_dout),
		.n_mreq (n_mreq), .n_iorq (n_iorq), .n_rd (n_rd), .n_wr (n_wr), .n_m1 (n_m1),
		.model_sel (model_sel), .key_data (key_data), .tape_in (tape_in),
		.ram_dout (ram_dout), .ram_addr (ram_addr), .ram_we (ram_we), .ram_rd (ram_rd),
		.cpu_din (cpu_din), .border_color (border_color), .ear_out (ear_out),
		.mic_out (mic_out)
	);

	assign ram_dout = ram_addr[7:0] ^ 8'h5A;   // RAM model, byte follows address

	always #50 clk_sys = ~clk_sys;

	// ========================================
	// Reporting and checks
	// ========================================

	task automatic end_with_failure(input string why);
		$display("RESULT: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check_ram_addr(input string name, input zx_pkg::ram_addr_t got,
		input zx_pkg::ram_addr_t want);
		checks = checks + 1;
		if (got !== want) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, want);
			end_with_failure("ram address mismatch");
		end
	endtask

	task automatic check_data(input string name, input zx_pkg::cpu_data_t got,
		input zx_pkg::cpu_data_t want);
		checks = checks + 1;
		if (got !== want) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, want);
			end_with_failure("data mismatch");
		end
	endtask

	task automatic check_border(input string name, input zx_pkg::border_t got,
		input zx_pkg::border_t want);
		checks = checks + 1;
		if (got !== want) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, want);
			end_with_failure("border mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		checks = checks + 1;
		if (got !== want) begin
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, want);
			end_with_failure("bit mismatch");
		end
	endtask

	// ========================================
	// Bus cycles
	// ========================================

	// Drive point is 10 units after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic bus_idle();
		n_mreq = 1'b1;
		n_iorq = 1'b1;
		n_rd   = 1'b1;
		n_wr   = 1'b1;
		n_m1   = 1'b1;
	endtask

	task automatic apply_reset(input zx_pkg::model_t model);
		bus_idle();
		model_sel = model;
		reset     = 1'b1;
		repeat (5) next_cycle();
		reset = 1'b0;
	endtask

	task automatic io_write(input zx_pkg::cpu_addr_t a, input zx_pkg::cpu_data_t d);
		addr     = a;
		cpu_dout = d;
		n_iorq   = 1'b0;
		n_wr     = 1'b0;
		repeat (3) next_cycle();
		bus_idle();
		repeat (2) next_cycle();
	endtask

	task automatic mem_access(input logic is_write, input zx_pkg::cpu_addr_t a,
		input zx_pkg::cpu_data_t d, input zx_pkg::ram_addr_t want);
		addr     = a;
		cpu_dout = d;
		n_mreq   = 1'b0;
		n_rd     = is_write;
		n_wr     = ~is_write;
		#30;
		check_ram_addr("ram_addr", ram_addr, want);
		if (is_write) begin
			check_bit("ram_we", ram_we, want[20:18] != ROM_AREA);   // ROM stays read only
			check_bit("ram_rd", ram_rd, 1'b0);
		end else begin
			check_bit("ram_rd", ram_rd, 1'b1);
			check_bit("ram_we", ram_we, 1'b0);
			check_data("cpu_din", cpu_din, want[7:0] ^ 8'h5A);
		end
		next_cycle();
		bus_idle();
		next_cycle();
	endtask

	task automatic io_read(input zx_pkg::cpu_addr_t a, input zx_pkg::cpu_data_t want);
		addr   = a;
		n_iorq = 1'b0;
		n_rd   = 1'b0;
		#30;
		check_data("cpu_din", cpu_din, want);
		check_bit("ram_rd", ram_rd, 1'b0);
		next_cycle();
		bus_idle();
		next_cycle();
	endtask

	function automatic bit is_pattern(input string s);
		return s.len() > 0 && s[0] != "#" && s[0] != "\n";
	endfunction

	// Run limit from the number of pattern lines
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the pattern run did not finish", cycle_count);
			end_with_failure("timeout");
		end
	end

	// ========================================
	// Pattern run
	// ========================================

	initial begin
		reset = 1'b1;
		addr = '0;
		cpu_dout = '0;
		model_sel = zx_pkg::model_128;
		key_data = '1;
		tape_in = 1'b0;
		bus_idle();
		checks = 0;
		cycle_count = 0;
		cycle_limit = 0;
		lines = 0;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the pattern file %s", PATTERN_FILE);
			end_with_failure("missing pattern file");
		end
		while ($fgets(line, fd) != 0) begin
			if (is_pattern(line)) lines = lines + 1;
		end
		$fclose(fd);
		cycle_limit = CYCLES_PER_LINE * lines + CYCLE_MARGIN;
		apply_reset(zx_pkg::model_128);
		fd = $fopen(PATTERN_FILE, "r");
		while ($fgets(line, fd) != 0) begin
			if (is_pattern(line)) begin
				n = $sscanf(line, "%s %h %h %h %h %h %h", cmd, model_v, addr_v, data_v,
					exp_v, key_v, tape_v);
				if (n != 7) begin
					$display("Malformed pattern line: %s", line);
					end_with_failure("bad pattern line");
				end
				key_data = key_v[4:0];
				tape_in  = tape_v[0];
				if (cmd == "reset") begin
					apply_reset(zx_pkg::model_t'(model_v[1:0]));
				end else if (cmd == "io_write") begin
					io_write(addr_v[15:0], data_v[7:0]);
				end else if (cmd == "mem_write") begin
					mem_access(1'b1, addr_v[15:0], data_v[7:0], exp_v[20:0]);
				end else if (cmd == "mem_read") begin
					mem_access(1'b0, addr_v[15:0], data_v[7:0], exp_v[20:0]);
				end else if (cmd == "io_read") begin
					io_read(addr_v[15:0], exp_v[7:0]);
				end else if (cmd == "ula") begin
					check_border("border_color", border_color, exp_v[2:0]);
					check_bit("mic_out", mic_out, exp_v[3]);
					check_bit("ear_out", ear_out, exp_v[4]);
				end else begin
					$display("Unknown command %s in the pattern file", cmd);
					end_with_failure("unknown command");
				end
			end
		end
		$fclose(fd);
		if (checks > 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("No checks were run from the pattern file");
			end_with_failure("empty pattern run");
		end
	end

endmodule

/* dv/zx_io_patterns.txt */
# cmd model addr data expect key tape, all hex, model 0=128K 1=48K 2=+3
# expect is ram_addr for mem_*, cpu_din for io_read, {ear,mic,border} for ula
reset     0 0000 00 000000 1F 0
mem_read  0 0123 00 158123 1F 0
io_write  0 7FFD 13 000000 1F 0
mem_read  0 C010 00 00C010 1F 0
mem_read  0 0123 00 15C123 1F 0
mem_write 0 0200 AA 15C200 1F 0
mem_write 0 4100 AA 014100 1F 0
mem_read  0 8005 00 008005 1F 0
io_write  0 7FFD 27 000000 1F 0
mem_read  0 C000 00 01C000 1F 0
mem_read  0 0000 00 158000 1F 0
io_write  0 7FFD 11 000000 1F 0
mem_read  0 C000 00 01C000 1F 0
mem_read  0 0000 00 158000 1F 0
io_write  0 00FE 1D 000000 1F 0
ula       0 0000 00 00001D 1F 0
io_read   0 00FE 00 0000AA 0A 1
io_read   0 00FE 00 0000F5 15 0
io_read   0 00FF 00 0000FF 15 0
io_write  0 00FE 0A 000000 1F 0
ula       0 0000 00 00000A 1F 0
reset     1 0000 00 000000 1F 0
ula       1 0000 00 000000 1F 0
mem_read  1 0123 00 17C123 1F 0
io_write  1 7FFD 14 000000 1F 0
mem_read  1 0123 00 17C123 1F 0
mem_read  1 C000 00 000000 1F 0
mem_write 1 0100 55 17C100 1F 0
reset     2 0000 00 000000 1F 0
mem_read  2 0000 00 160000 1F 0
io_write  2 7FFD 10 000000 1F 0
mem_read  2 0000 00 164000 1F 0
io_write  2 1FFD 04 000000 1F 0
mem_read  2 0000 00 16C000 1F 0
io_write  2 1FFD 01 000000 1F 0
mem_read  2 4010 00 004010 1F 0
mem_write 2 0020 33 000020 1F 0
io_write  2 1FFD 03 000000 1F 0
mem_read  2 0000 00 010000 1F 0
mem_read  2 C000 00 01C000 1F 0
io_write  2 1FFD 05 000000 1F 0
mem_read  2 C000 00 00C000 1F 0
io_write  2 1FFD 07 000000 1F 0
mem_read  2 4000 00 01C000 1F 0
io_write  2 7FFD 20 000000 1F 0
io_write  2 1FFD 00 000000 1F 0
mem_read  2 4000 00 01C000 1F 0
mem_read  2 8000 00 018000 1F 0

/* flist.f */
src/zx_pkg.sv
src/paging_regs.sv
src/ula_port.sv
src/memory_bus.sv
src/zx_io_top.sv
dv/zx_io_asserts.sv
dv/tb_zx_io.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
LINT      = --lint-only --timing
TOP       = tb_zx_io
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

# The log decides the result, the simulator exit code is not trusted
run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
